//--- include/mem_ex_defines.svh
`ifndef MEM_EX_DEFINES_SVH
`define MEM_EX_DEFINES_SVH

// number of latch entries between MEM and EX
`define MEM_EX_DEPTH 8

// operand value width
`define MEM_EX_VALUE_W 32

// producer tag width, one tag per in-flight result
`define MEM_EX_TAG_W 5

// credits EX hands out after reset
`define MEM_EX_EX_CREDITS 2

`endif

//--- src/uop_pkg.sv
package uop_pkg;

    // alu opcodes carried in the fixed part of a latch
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SHL  = 3'd5,
        ALU_SHR  = 3'd6,
        ALU_PASS = 3'd7
    } alu_op_e;

    // architectural destination register index
    typedef logic [4:0] dest_reg_t;

    // instruction pointer of the micro-op
    typedef logic [31:0] eip_t;

    // non-modifiable part of a latch entry
    // written once at enqueue, read unchanged at issue
    typedef struct packed {
        alu_op_e   opcode;
        eip_t      eip;
        dest_reg_t dest;
    } uop_fixed_t;

endpackage

//--- src/wake_pkg.sv
package wake_pkg;

    `include "mem_ex_defines.svh"

    // producer tag of a pending result
    typedef logic [`MEM_EX_TAG_W-1:0] tag_t;

    // one source operand, wake=1 means value holds real data
    typedef struct packed {
        logic                       wake;
        tag_t                       tag;
        logic [`MEM_EX_VALUE_W-1:0] value;
    } operand_t;

    // result broadcast from the later stages
    typedef struct packed {
        logic                       valid;
        tag_t                       tag;
        logic [`MEM_EX_VALUE_W-1:0] value;
    } result_t;

    // modifiable part of a latch entry
    typedef struct packed {
        operand_t src1;
        operand_t src2;
    } entry_mod_t;

endpackage

//--- src/wake_if.sv
`timescale 1ns/1ps
`include "mem_ex_defines.svh"

interface wake_if (
    input logic clk,
    input logic arst_n
);
    import wake_pkg::*;

    // stored operands and slot occupancy, from the queue
    entry_mod_t [`MEM_EX_DEPTH-1:0] old_ops;
    logic [`MEM_EX_DEPTH-1:0]       occupied;
    entry_mod_t                     in_ops;

    // rewrite request per entry, from the wakeup unit
    logic [`MEM_EX_DEPTH-1:0]       modify_vector;
    entry_mod_t [`MEM_EX_DEPTH-1:0] new_ops;
    entry_mod_t                     in_ops_woken;

    modport queue (
        output old_ops, occupied, in_ops,
        input  modify_vector, new_ops, in_ops_woken
    );

    modport wakeup (
        input  clk, arst_n,
        input  old_ops, occupied, in_ops,
        output modify_vector, new_ops, in_ops_woken
    );

endinterface

//--- src/operand_wakeup.sv
`timescale 1ns/1ps
`include "mem_ex_defines.svh"

module operand_wakeup (
    wake_if.wakeup             wk,
    input  wake_pkg::result_t  res
);
    import wake_pkg::*;

    localparam int DEPTH = `MEM_EX_DEPTH;

    entry_mod_t [DEPTH-1:0] woken;
    logic [DEPTH-1:0]       hit;

    // only a sleeping operand can match, an awake one keeps its value
    function automatic logic tag_hit(operand_t op, result_t r);
        return r.valid && !op.wake && (op.tag == r.tag);
    endfunction

    function automatic operand_t wake_op(operand_t op, result_t r);
        operand_t o;
        o = op;
        if (tag_hit(op, r)) begin
            o.wake  = 1'b1;
            o.value = r.value;
        end
        return o;
    endfunction

    // match the broadcast against every stored entry
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            woken[i].src1 = wake_op(wk.old_ops[i].src1, res);
            woken[i].src2 = wake_op(wk.old_ops[i].src2, res);
            hit[i] = tag_hit(wk.old_ops[i].src1, res) ||
                     tag_hit(wk.old_ops[i].src2, res);
        end
    end

    assign wk.new_ops       = woken;
    assign wk.modify_vector = hit & wk.occupied;

    // incoming entry sees the same broadcast so an enqueue never misses it
    assign wk.in_ops_woken.src1 = wake_op(wk.in_ops.src1, res);
    assign wk.in_ops_woken.src2 = wake_op(wk.in_ops.src2, res);

    // a requested rewrite is in the latch one edge later unless the entry left
    for (genvar i = 0; i < DEPTH; i++) begin : g_rewrite_chk
        a_rewrite_lands: assert property (
            @(posedge wk.clk) disable iff (!wk.arst_n)
            wk.modify_vector[i] |=>
                !wk.occupied[i] || (wk.old_ops[i] == $past(wk.new_ops[i]))
        );
    end

endmodule

//--- src/mem_ex_queue.sv
`timescale 1ns/1ps
`include "mem_ex_defines.svh"

module mem_ex_queue (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              in_valid,
    input  uop_pkg::uop_fixed_t               in_fixed,
    input  wake_pkg::entry_mod_t              in_ops,
    wake_if.queue                             wk,
    input  logic                              pop,
    input  logic                              flush,
    output logic                              head_valid,
    output uop_pkg::uop_fixed_t               head_fixed,
    output wake_pkg::entry_mod_t              head_ops,
    output logic [$clog2(`MEM_EX_DEPTH):0]    credit_cnt
);
    import uop_pkg::*;
    import wake_pkg::*;

    localparam int DEPTH = `MEM_EX_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // non-modifiable half of each latch
    uop_fixed_t             fixed_q [DEPTH];
    // modifiable half, rewritten in place while the entry waits
    entry_mod_t [DEPTH-1:0] mod_q;

    logic [DEPTH-1:0] occ;
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(DEPTH));
    // flush wins over both enqueue and pop
    assign wr_en = in_valid && !flush && !full;
    assign rd_en = pop && !flush;

    // payload latches
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (wr_en && (tail == PTR_W'(i))) begin
                fixed_q[i] <= in_fixed;
                mod_q[i]   <= wk.in_ops_woken;
            end else if (wk.modify_vector[i]) begin
                mod_q[i] <= wk.new_ops[i];
            end
        end
    end

    // pointers, occupancy and credit return
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            occ        <= '0;
            credit_cnt <= '0;
        end else if (flush) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            occ        <= '0;
            // every held slot goes back to MEM at once
            credit_cnt <= count;
        end else begin
            if (wr_en) begin
                tail      <= ptr_inc(tail);
                occ[tail] <= 1'b1;
            end
            if (rd_en) begin
                head      <= ptr_inc(head);
                occ[head] <= 1'b0;
            end
            count      <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
            credit_cnt <= CNT_W'(rd_en);
        end
    end

    assign head_valid = occ[head];
    assign head_fixed = fixed_q[head];
    assign head_ops   = mod_q[head];

    // wakeup unit looks at every latch and the incoming one
    assign wk.old_ops  = mod_q;
    assign wk.occupied = occ;
    assign wk.in_ops   = in_ops;

    // MEM must hold a credit, so a full queue never sees a write
    a_no_write_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        in_valid |-> !full
    );

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!arst_n)
        pop |-> (count != '0)
    );

    // count and the per-slot bits must never drift apart
    a_count_matches_occ: assert property (
        @(posedge clk) disable iff (!arst_n)
        count == CNT_W'($countones(occ))
    );

endmodule

//--- src/ex_issue_credit.sv
`timescale 1ns/1ps
`include "mem_ex_defines.svh"

module ex_issue_credit (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        head_valid,
    input  uop_pkg::uop_fixed_t         head_fixed,
    input  wake_pkg::entry_mod_t        head_ops,
    input  logic                        flush,
    input  logic                        ex_credit,
    output logic                        pop,
    output logic                        ex_valid,
    output uop_pkg::uop_fixed_t         ex_fixed,
    output logic [`MEM_EX_VALUE_W-1:0]  ex_src1,
    output logic [`MEM_EX_VALUE_W-1:0]  ex_src2
);
    localparam int CRED_MAX = `MEM_EX_EX_CREDITS;
    localparam int CRED_W   = $clog2(CRED_MAX + 1);

    logic [CRED_W-1:0] credits;
    logic              ops_awake;
    logic              issue;

    assign ops_awake = head_ops.src1.wake && head_ops.src2.wake;

    // in-order: only the head is ever considered
    assign issue = head_valid && ops_awake && (credits != '0) && !flush;

    assign pop      = issue;
    assign ex_valid = issue;
    assign ex_fixed = head_fixed;
    assign ex_src1  = head_ops.src1.value;
    assign ex_src2  = head_ops.src2.value;

    // spend on issue, refill on ex_credit, both can land together
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= CRED_W'(CRED_MAX);
        end else begin
            case ({issue, ex_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // EX returns no more than it was given
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!arst_n)
        credits <= CRED_W'(CRED_MAX)
    );

endmodule

//--- src/mem_ex_stage_top.sv
`timescale 1ns/1ps
`include "mem_ex_defines.svh"

module mem_ex_stage_top (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              mem_valid,
    input  uop_pkg::alu_op_e                  mem_opcode,
    input  logic [31:0]                       mem_eip,
    input  logic [4:0]                        mem_dest,
    input  logic                              mem_src1_ready,
    input  logic [`MEM_EX_TAG_W-1:0]          mem_src1_tag,
    input  logic [`MEM_EX_VALUE_W-1:0]        mem_src1_value,
    input  logic                              mem_src2_ready,
    input  logic [`MEM_EX_TAG_W-1:0]          mem_src2_tag,
    input  logic [`MEM_EX_VALUE_W-1:0]        mem_src2_value,
    input  logic                              res_valid,
    input  logic [`MEM_EX_TAG_W-1:0]          res_tag,
    input  logic [`MEM_EX_VALUE_W-1:0]        res_value,
    input  logic                              flush,
    input  logic                              ex_credit,
    output logic                              ex_valid,
    output uop_pkg::alu_op_e                  ex_opcode,
    output logic [31:0]                       ex_eip,
    output logic [4:0]                        ex_dest,
    output logic [`MEM_EX_VALUE_W-1:0]        ex_src1_value,
    output logic [`MEM_EX_VALUE_W-1:0]        ex_src2_value,
    output logic [$clog2(`MEM_EX_DEPTH):0]    mem_credit_cnt
);
    import uop_pkg::*;
    import wake_pkg::*;

    uop_fixed_t in_fixed;
    entry_mod_t in_ops;
    result_t    res;
    logic       head_valid;
    uop_fixed_t head_fixed;
    entry_mod_t head_ops;
    logic       pop;
    uop_fixed_t ex_fixed;

    wake_if wk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    // pack MEM side ports
    assign in_fixed.opcode = mem_opcode;
    assign in_fixed.eip    = mem_eip;
    assign in_fixed.dest   = mem_dest;

    assign in_ops.src1.wake  = mem_src1_ready;
    assign in_ops.src1.tag   = mem_src1_tag;
    assign in_ops.src1.value = mem_src1_value;
    assign in_ops.src2.wake  = mem_src2_ready;
    assign in_ops.src2.tag   = mem_src2_tag;
    assign in_ops.src2.value = mem_src2_value;

    assign res.valid = res_valid;
    assign res.tag   = res_tag;
    assign res.value = res_value;

    mem_ex_queue u_queue (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (mem_valid),
        .in_fixed   (in_fixed),
        .in_ops     (in_ops),
        .wk         (wk.queue),
        .pop        (pop),
        .flush      (flush),
        .head_valid (head_valid),
        .head_fixed (head_fixed),
        .head_ops   (head_ops),
        .credit_cnt (mem_credit_cnt)
    );

    operand_wakeup u_wakeup (
        .wk  (wk.wakeup),
        .res (res)
    );

    ex_issue_credit u_issue (
        .clk        (clk),
        .arst_n     (arst_n),
        .head_valid (head_valid),
        .head_fixed (head_fixed),
        .head_ops   (head_ops),
        .flush      (flush),
        .ex_credit  (ex_credit),
        .pop        (pop),
        .ex_valid   (ex_valid),
        .ex_fixed   (ex_fixed),
        .ex_src1    (ex_src1_value),
        .ex_src2    (ex_src2_value)
    );

    // unpack EX side
    assign ex_opcode = ex_fixed.opcode;
    assign ex_eip    = ex_fixed.eip;
    assign ex_dest   = ex_fixed.dest;

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);
    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held for 4 cycles, released between edges
    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

//--- verif/mem_ex_tb.sv
`timescale 1ns/1ps
`include "mem_ex_defines.svh"

module mem_ex_tb;
    import uop_pkg::*;

    localparam int DEPTH   = `MEM_EX_DEPTH;
    localparam int EX_MAX  = `MEM_EX_EX_CREDITS;
    localparam int TIMEOUT = 200;

    typedef logic [`MEM_EX_TAG_W-1:0]   tag_t;
    typedef logic [`MEM_EX_VALUE_W-1:0] val_t;

    // one expected micro-op of the reference queue
    typedef struct packed {
        logic [2:0]  opcode;
        logic [31:0] eip;
        logic [4:0]  dest;
        logic        r1;
        tag_t        t1;
        val_t        v1;
        logic        r2;
        tag_t        t2;
        val_t        v2;
    } exp_uop_t;

    logic     clk;
    logic     arst_n;
    logic     mem_valid;
    alu_op_e  mem_opcode;
    logic [31:0] mem_eip;
    logic [4:0]  mem_dest;
    logic     mem_src1_ready;
    tag_t     mem_src1_tag;
    val_t     mem_src1_value;
    logic     mem_src2_ready;
    tag_t     mem_src2_tag;
    val_t     mem_src2_value;
    logic     res_valid;
    tag_t     res_tag;
    val_t     res_value;
    logic     flush;
    logic     ex_credit;
    logic     ex_valid;
    alu_op_e  ex_opcode;
    logic [31:0] ex_eip;
    logic [4:0]  ex_dest;
    val_t     ex_src1_value;
    val_t     ex_src2_value;
    logic [$clog2(DEPTH):0] mem_credit_cnt;

    exp_uop_t exp_q[$];
    int       mem_cred = DEPTH;
    int       ex_cred = EX_MAX;
    int       issued = 0;
    int       flushed = 0;
    int       credit_sum = 0;
    int       errors = 0;
    int       test_errors = 0;
    int       tests_run = 0;
    int       tests_failed = 0;
    int       flush_expect = 0;
    int       credit_req = 0;
    bit       flush_pending = 0;
    bit       auto_credit = 1;
    string    test_name = "reset";
    logic [31:0] rng = 32'd75;

    tb_clock_gen u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    mem_ex_stage_top DUT (.*);

    function logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task mismatch(string what, logic [63:0] expv, logic [63:0] actv);
        $display("error %s: %s expected %0h actual %0h", test_name, what, expv, actv);
        errors++;
    endtask

    task failure(string msg);
        $display("%s: %s", test_name, msg);
        errors++;
    endtask

    task timeout_fail(string what);
        $display("timeout in %s while waiting for %s", test_name, what);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    // model of the tag match against the current broadcast
    function automatic exp_uop_t wake_entry(exp_uop_t e);
        exp_uop_t w;
        w = e;
        if (res_valid && !w.r1 && w.t1 == res_tag) begin
            w.r1 = 1'b1;
            w.v1 = res_value;
        end
        if (res_valid && !w.r2 && w.t2 == res_tag) begin
            w.r2 = 1'b1;
            w.v2 = res_value;
        end
        return w;
    endfunction

    // checks and model update, once per cycle while inputs and outputs are stable
    task observe_cycle();
        exp_uop_t e;
        exp_uop_t h;
        credit_sum += int'(mem_credit_cnt);
        mem_cred   += int'(mem_credit_cnt);
        if (flush_pending) begin
            flush_pending = 0;
            assert (int'(mem_credit_cnt) == flush_expect)
                else mismatch("flush credits", 64'(flush_expect), 64'(mem_credit_cnt));
        end
        if (flush) begin
            flush_expect  = exp_q.size();
            flushed      += exp_q.size();
            flush_pending = 1;
            exp_q.delete();
        end else begin
            if (ex_valid) begin
                assert (ex_cred > 0) else failure("issue without an EX credit");
                if (exp_q.size() == 0) begin
                    failure("issue while the reference queue is empty");
                end else begin
                    h = exp_q.pop_front();
                    assert (h.r1 && h.r2) else failure("issue before both operands woke");
                    assert (ex_opcode == h.opcode)
                        else mismatch("opcode", 64'(h.opcode), 64'(ex_opcode));
                    assert (ex_eip == h.eip) else mismatch("eip", 64'(h.eip), 64'(ex_eip));
                    assert (ex_dest == h.dest) else mismatch("dest", 64'(h.dest), 64'(ex_dest));
                    assert (ex_src1_value == h.v1)
                        else mismatch("src1", 64'(h.v1), 64'(ex_src1_value));
                    assert (ex_src2_value == h.v2)
                        else mismatch("src2", 64'(h.v2), 64'(ex_src2_value));
                end
                issued++;
                ex_cred--;
            end
            foreach (exp_q[i]) exp_q[i] = wake_entry(exp_q[i]);
            if (mem_valid) begin
                e = '{mem_opcode, mem_eip, mem_dest,
                      mem_src1_ready, mem_src1_tag, mem_src1_value,
                      mem_src2_ready, mem_src2_tag, mem_src2_value};
                exp_q.push_back(wake_entry(e));
            end
        end
        if (ex_credit) ex_cred++;
    endtask

    always @(negedge clk) begin
        #1;
        if (arst_n) observe_cycle();
    end

    // EX side, returns credits on its own or on request
    always @(negedge clk) begin
        if (credit_req > 0) begin
            ex_credit <= 1'b1;
            credit_req--;
        end else begin
            ex_credit <= auto_credit && (ex_cred < EX_MAX);
        end
    end

    a_no_issue_in_flush: assert property (
        @(posedge clk) disable iff (!arst_n) flush |-> !ex_valid
    ) else failure("ex_valid high during a flush");

    a_mem_outstanding: assert property (
        @(posedge clk) disable iff (!arst_n) mem_cred >= 0 && mem_cred <= DEPTH
    ) else failure("MEM outstanding entries out of range");

    a_ex_credit_range: assert property (
        @(posedge clk) disable iff (!arst_n) ex_cred >= 0 && ex_cred <= EX_MAX
    ) else failure("EX credit count out of range");

    task send_uop(bit r1, tag_t t1, bit r2, tag_t t2, bit with_res, tag_t rt, val_t rv);
        int waited;
        logic [31:0] r;
        waited = 0;
        while (mem_cred <= 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= TIMEOUT) timeout_fail("a MEM credit");
        r              = xorshift32();
        mem_opcode     = alu_op_e'(r[2:0]);
        mem_dest       = r[8:4];
        mem_eip        = xorshift32();
        mem_src1_ready = r1;
        mem_src1_tag   = t1;
        mem_src1_value = xorshift32();
        mem_src2_ready = r2;
        mem_src2_tag   = t2;
        mem_src2_value = xorshift32();
        res_valid      = with_res;
        res_tag        = rt;
        res_value      = rv;
        mem_valid      = 1'b1;
        mem_cred--;
        @(negedge clk);
        mem_valid = 1'b0;
        res_valid = 1'b0;
    endtask

    task broadcast(tag_t t, val_t v);
        res_valid = 1'b1;
        res_tag   = t;
        res_value = v;
        @(negedge clk);
        res_valid = 1'b0;
    endtask

    // queue empty and EX credits all back
    task wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || ex_cred != EX_MAX) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) timeout_fail("the queue to drain");
    endtask

    task wait_issued(int target);
        int n;
        n = 0;
        while (issued < target && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) timeout_fail("an issue");
    endtask

    task begin_test(string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task end_test();
        tests_run++;
        if (errors > test_errors) begin
            tests_failed++;
            $display("test %s: failed", test_name);
        end else begin
            $display("test %s: passed", test_name);
        end
    endtask

    initial begin
        int n;
        int start;
        mem_valid = 0;
        mem_opcode = ALU_ADD;
        mem_eip = '0;
        mem_dest = '0;
        mem_src1_ready = 0;
        mem_src1_tag = '0;
        mem_src1_value = '0;
        mem_src2_ready = 0;
        mem_src2_tag = '0;
        mem_src2_value = '0;
        res_valid = 0;
        res_tag = '0;
        res_value = '0;
        flush = 0;
        ex_credit = 0;
        n = 0;
        while (!arst_n && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) timeout_fail("reset release");

        begin_test("reset");
        repeat (3) @(negedge clk);
        assert (!ex_valid) else mismatch("ex_valid", 64'(0), 64'(ex_valid));
        assert (mem_credit_cnt == '0) else mismatch("mem_credit_cnt", 64'(0), 64'(mem_credit_cnt));
        assert (issued == 0) else mismatch("issued", 64'(0), 64'(issued));
        end_test();

        begin_test("pass_through");
        repeat (4) begin
            send_uop(1, '0, 1, '0, 0, '0, '0);
            // one cycle latency into an empty queue
            assert (ex_valid) else mismatch("ex_valid after enqueue", 64'(1), 64'(ex_valid));
            wait_drain();
        end
        repeat (6) send_uop(1, 5'd1, 1, 5'd2, 0, '0, '0);
        wait_drain();
        end_test();

        begin_test("wakeup");
        start = issued;
        send_uop(0, 5'd3, 1, '0, 0, '0, '0);
        repeat (5) @(negedge clk);
        assert (issued == start) else mismatch("issued before wakeup", 64'(start), 64'(issued));
        broadcast(5'd3, xorshift32());
        wait_drain();
        send_uop(1, '0, 0, 5'd9, 1, 5'd9, xorshift32());
        send_uop(0, 5'd11, 0, 5'd11, 0, '0, '0);
        send_uop(1, '0, 0, 5'd12, 0, '0, '0);
        broadcast(5'd12, xorshift32());
        repeat (3) @(negedge clk);
        broadcast(5'd11, xorshift32());
        wait_drain();
        end_test();

        begin_test("ex_backpressure");
        auto_credit = 0;
        start = issued;
        repeat (4) send_uop(1, '0, 1, '0, 0, '0, '0);
        wait_issued(start + EX_MAX);
        repeat (4) @(negedge clk);
        assert (issued == start + EX_MAX)
            else mismatch("issued without credit", 64'(start + EX_MAX), 64'(issued));
        credit_req = 1;
        wait_issued(start + EX_MAX + 1);
        repeat (4) @(negedge clk);
        assert (issued == start + EX_MAX + 1)
            else mismatch("issued per credit", 64'(start + EX_MAX + 1), 64'(issued));
        auto_credit = 1;
        wait_drain();
        end_test();

        begin_test("flush");
        repeat (3) send_uop(0, 5'd17, 1, '0, 0, '0, '0);
        // the head wakes here so it could issue in the flush cycle
        send_uop(1, '0, 0, 5'd18, 1, 5'd17, xorshift32());
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        // stale tags must not bring flushed entries back
        broadcast(5'd17, xorshift32());
        broadcast(5'd18, xorshift32());
        wait_drain();
        send_uop(1, '0, 1, '0, 0, '0, '0);
        wait_drain();
        end_test();

        begin_test("mem_credits");
        assert (credit_sum == issued + flushed)
            else mismatch("credit sum", 64'(issued + flushed), 64'(credit_sum));
        assert (mem_cred == DEPTH) else mismatch("MEM credits", 64'(DEPTH), 64'(mem_cred));
        end_test();

        $display("tests %0d failed %0d errors %0d issued %0d flushed %0d",
                 tests_run, tests_failed, errors, issued, flushed);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
src/uop_pkg.sv
src/wake_pkg.sv
src/wake_if.sv
src/operand_wakeup.sv
src/mem_ex_queue.sv
src/ex_issue_credit.sv
src/mem_ex_stage_top.sv
verif/tb_clock_gen.sv
verif/mem_ex_tb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --assert --timing
TOP   = mem_ex_tb
FLIST = flist.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
